// ==== source/core_bridge_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// core bridge package
// shared widths, bridge register map and the loader address view
//////////////////////////////////////////////////////////////////////

package core_bridge_pkg;

  // bridge bus word, used for both address and data
  typedef logic [31:0] bridge_word_t;

  // 16-bit memory data
  typedef logic [15:0] halfword_t;

  // lcd off overlay alpha
  typedef logic [7:0] alpha_t;

  // memory word address width
  localparam int word_addr_w = 25;

  // bridge address seen as a flat register address or as region/offset
  typedef union packed {
    bridge_word_t reg_addr;
    struct packed {
      logic [3:0]  region;
      logic [27:0] offset;
    } loader;
  } bridge_addr_u;

  // region code of loader writes
  localparam logic [3:0] loader_region = 4'h1;

  ////////////////////////////////////////////////////////////////////
  // register map

  localparam bridge_word_t reg_reset_addr      = 32'h0000_0000;
  localparam bridge_word_t reg_lcd_timing_addr = 32'h0000_0200;
  localparam bridge_word_t reg_show_off_addr   = 32'h0000_0210;
  localparam bridge_word_t reg_off_alpha_addr  = 32'h0000_0214;
  localparam bridge_word_t reg_status_addr     = 32'h0000_0218;

endpackage

// ==== source/word_if.sv ====
//////////////////////////////////////////////////////////////////////
// loader word link
// halfword pushes from the loader into the memory write FIFO
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface word_if #(
  parameter int fifo_depth = 4
);
  import core_bridge_pkg::*;

  logic                        push;
  logic [word_addr_w-1:0]      addr;
  halfword_t                   data;
  // free FIFO slots
  logic [$clog2(fifo_depth):0] space;

  modport loader (output push, output addr, output data, input space);

  modport port (input push, input addr, input data, output space);

endinterface

// ==== source/settings_regs.sv ====
//////////////////////////////////////////////////////////////////////
// settings registers
// lcd settings, host triggered core reset pulse and bridge read-back
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module settings_regs #(
  parameter int reset_cycles = 32
) (
  input  logic                          clk_74a,
  input  logic                          rst,
  input  logic                          bridge_wr,
  input  core_bridge_pkg::bridge_word_t bridge_addr,
  input  core_bridge_pkg::bridge_word_t bridge_wr_data,
  input  logic                          overflow,
  output core_bridge_pkg::bridge_word_t bridge_rd_data,
  output logic                          core_reset,
  output logic                          accurate_lcd_timing,
  output core_bridge_pkg::alpha_t       lcd_off_alpha
);

  import core_bridge_pkg::*;

  localparam int cnt_w = $clog2(reset_cycles + 1);

  bridge_addr_u     addr_v;
  logic             lcd_timing_q;
  logic             show_lcd_off;
  alpha_t           off_alpha;
  logic [cnt_w-1:0] reset_cnt;

  // flat register view of the bridge address
  assign addr_v = bridge_addr;

  ////////////////////////////////////////////////////////////////////
  // host writes

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      lcd_timing_q <= 1'b0;
      show_lcd_off <= 1'b0;
      off_alpha    <= '0;
    end else if (bridge_wr) begin
      case (addr_v.reg_addr)
        reg_lcd_timing_addr: lcd_timing_q <= bridge_wr_data[0];
        reg_show_off_addr:   show_lcd_off <= bridge_wr_data[0];
        reg_off_alpha_addr:  off_alpha    <= bridge_wr_data[7:0];
        default: ;
      endcase
    end
  end

  // reset pulse, reloads on every write to the reset address
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      reset_cnt <= '0;
    end else if (bridge_wr && addr_v.reg_addr == reg_reset_addr) begin
      reset_cnt <= cnt_w'(reset_cycles);
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // setting outputs

  assign core_reset          = (reset_cnt != '0);
  assign accurate_lcd_timing = lcd_timing_q;

  // overlay alpha only while the lcd off image is shown
  assign lcd_off_alpha = show_lcd_off ? off_alpha : '0;

  ////////////////////////////////////////////////////////////////////
  // read-back mux

  always_comb begin
    bridge_rd_data = '0;
    case (addr_v.reg_addr)
      reg_lcd_timing_addr: bridge_rd_data[0]   = lcd_timing_q;
      reg_show_off_addr:   bridge_rd_data[0]   = show_lcd_off;
      reg_off_alpha_addr:  bridge_rd_data[7:0] = off_alpha;
      reg_status_addr:     bridge_rd_data[0]   = overflow;
      default: ;
    endcase
  end

endmodule

// ==== source/data_loader.sv ====
//////////////////////////////////////////////////////////////////////
// data loader
// splits 32-bit region writes into two halfword pushes, high half first
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module data_loader (
  input  logic                          clk_74a,
  input  logic                          rst,
  input  logic                          bridge_wr,
  input  core_bridge_pkg::bridge_word_t bridge_addr,
  input  core_bridge_pkg::bridge_word_t bridge_wr_data,
  word_if.loader                        words,
  output logic                          overflow
);

  import core_bridge_pkg::*;

  bridge_addr_u           addr_v;
  logic [word_addr_w-1:0] word_addr;
  logic                   region_wr;
  logic                   room;
  logic                   accept;
  logic                   pend_valid;
  logic [word_addr_w-1:0] pend_addr;
  halfword_t              pend_data;

  assign addr_v    = bridge_addr;
  // byte offset to halfword address
  assign word_addr = addr_v.loader.offset[word_addr_w:1];
  assign region_wr = bridge_wr && (addr_v.loader.region == loader_region);

  // a low half still in flight counts against free space
  assign room   = words.push ? (words.space > 2) : (words.space > 1);
  assign accept = region_wr && room && !pend_valid;

  // push control
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      words.push <= 1'b0;
      pend_valid <= 1'b0;
    end else begin
      words.push <= accept || pend_valid;
      pend_valid <= accept;
    end
  end

  // push payload and the held low half
  always_ff @(posedge clk_74a) begin
    if (accept) begin
      words.addr <= word_addr;
      words.data <= bridge_wr_data[31:16];
      pend_addr  <= word_addr + 1'b1;
      pend_data  <= bridge_wr_data[15:0];
    end else if (pend_valid) begin
      words.addr <= pend_addr;
      words.data <= pend_data;
    end
  end

  // sticky until reset
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      overflow <= 1'b0;
    end else if (region_wr && !accept) begin
      overflow <= 1'b1;
    end
  end

endmodule

// ==== source/mem_write_port.sv ====
//////////////////////////////////////////////////////////////////////
// memory write port
// word FIFO drained into the memory write strobe under credit control
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_write_port #(
  parameter int mem_credits = 4,
  parameter int fifo_depth  = 4
) (
  input  logic                                    clk_74a,
  input  logic                                    rst,
  input  logic                                    mem_credit,
  word_if.port                                    words,
  output logic                                    mem_wr,
  output logic [core_bridge_pkg::word_addr_w-1:0] mem_addr,
  output core_bridge_pkg::halfword_t              mem_data
);

  import core_bridge_pkg::*;

  localparam int ptr_w  = $clog2(fifo_depth);
  localparam int cred_w = $clog2(mem_credits + 1);
  localparam logic [ptr_w:0] full_cnt = (ptr_w + 1)'(fifo_depth);

  logic [word_addr_w-1:0] addr_mem [fifo_depth];
  halfword_t              data_mem [fifo_depth];
  logic [ptr_w-1:0]       wr_ptr;
  logic [ptr_w-1:0]       rd_ptr;
  logic [ptr_w:0]         count;
  logic [cred_w-1:0]      credits;
  logic                   pop;

  // one word leaves per cycle while a credit is held
  assign pop         = (count != '0) && (credits != '0);
  assign words.space = full_cnt - count;

  ////////////////////////////////////////////////////////////////////
  // word FIFO

  always_ff @(posedge clk_74a) begin
    if (words.push) begin
      addr_mem[wr_ptr] <= words.addr;
      data_mem[wr_ptr] <= words.data;
    end
  end

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (words.push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({words.push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // credits and memory outputs

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      credits <= cred_w'(mem_credits);
      mem_wr  <= 1'b0;
    end else begin
      mem_wr <= pop;
      // returned credit and a spent one cancel out
      case ({pop, mem_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk_74a) begin
    if (pop) begin
      mem_addr <= addr_mem[rd_ptr];
      mem_data <= data_mem[rd_ptr];
    end
  end

endmodule

// ==== source/sound_i2s.sv ====
//////////////////////////////////////////////////////////////////////
// sound serializer
// one-bit core sound to a 16-bit I2S style stream, both channels
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module sound_i2s #(
  parameter int bit_cycles = 4
) (
  input  logic clk_74a,
  input  logic rst,
  input  logic sound,
  output logic audio_mclk,
  output logic audio_lrck,
  output logic audio_dac
);

  import core_bridge_pkg::*;

  localparam int cyc_w = $clog2(bit_cycles);
  localparam logic [cyc_w-1:0] cyc_last = cyc_w'(bit_cycles - 1);
  localparam logic [cyc_w-1:0] cyc_half = cyc_w'(bit_cycles / 2);

  logic [cyc_w-1:0] cyc_cnt;
  logic [3:0]       bit_idx;
  logic             lrck_q;
  logic             slot_end;
  logic             frame_end;
  halfword_t        sample;

  assign slot_end  = (cyc_cnt == cyc_last);
  // last bit of the right channel
  assign frame_end = slot_end && (bit_idx == 4'd15) && lrck_q;

  // bit timing and channel select
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      cyc_cnt <= '0;
      bit_idx <= '0;
      lrck_q  <= 1'b0;
    end else begin
      cyc_cnt <= slot_end ? '0 : cyc_cnt + 1'b1;
      if (slot_end) begin
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == 4'd15) begin
          lrck_q <= ~lrck_q;
        end
      end
    end
  end

  // new sample each frame, reset also starts a frame
  always_ff @(posedge clk_74a) begin
    if (rst || frame_end) begin
      sample <= {2'b00, {13{sound}}, 1'b0};
    end
  end

  assign audio_mclk = (cyc_cnt < cyc_half);
  assign audio_lrck = lrck_q;
  // msb first
  assign audio_dac  = sample[4'd15 - bit_idx];

endmodule

// ==== source/core_bridge_top.sv ====
//////////////////////////////////////////////////////////////////////
// core bridge top level
// connects the host bridge, memory write port and audio pins
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module core_bridge_top #(
  parameter int reset_cycles = 32,
  parameter int mem_credits  = 4,
  parameter int fifo_depth   = 4,
  parameter int bit_cycles   = 4
) (
  input  logic                                       clk_74a,
  input  logic                                       rst,
  input  logic                                       bridge_wr,
  input  logic                                       sound,
  input  core_bridge_pkg::bridge_word_t              bridge_addr,
  input  core_bridge_pkg::bridge_word_t              bridge_wr_data,
  output core_bridge_pkg::bridge_word_t              bridge_rd_data,
  output logic                                       core_reset,
  output logic                                       accurate_lcd_timing,
  output core_bridge_pkg::alpha_t                    lcd_off_alpha,
  output logic                                       mem_wr,
  output logic [core_bridge_pkg::word_addr_w-1:0]    mem_addr,
  output core_bridge_pkg::halfword_t                 mem_data,
  input  logic                                       mem_credit,
  output logic                                       audio_mclk,
  output logic                                       audio_lrck,
  output logic                                       audio_dac
);

  logic overflow;

  word_if #(.fifo_depth(fifo_depth)) words_i ();

  ////////////////////////////////////////////////////////////////////
  // settings

  settings_regs #(.reset_cycles(reset_cycles)) settings_regs_i (
    .clk_74a             (clk_74a),
    .rst                 (rst),
    .bridge_wr           (bridge_wr),
    .bridge_addr         (bridge_addr),
    .bridge_wr_data      (bridge_wr_data),
    .overflow            (overflow),
    .bridge_rd_data      (bridge_rd_data),
    .core_reset          (core_reset),
    .accurate_lcd_timing (accurate_lcd_timing),
    .lcd_off_alpha       (lcd_off_alpha)
  );

  ////////////////////////////////////////////////////////////////////
  // data loading

  data_loader data_loader_i (
    .clk_74a        (clk_74a),
    .rst            (rst),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .words          (words_i.loader),
    .overflow       (overflow)
  );

  mem_write_port #(
    .mem_credits (mem_credits),
    .fifo_depth  (fifo_depth)
  ) mem_write_port_i (
    .clk_74a    (clk_74a),
    .rst        (rst),
    .mem_credit (mem_credit),
    .words      (words_i.port),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data)
  );

  ////////////////////////////////////////////////////////////////////
  // sound

  sound_i2s #(.bit_cycles(bit_cycles)) sound_i2s_i (
    .clk_74a    (clk_74a),
    .rst        (rst),
    .sound      (sound),
    .audio_mclk (audio_mclk),
    .audio_lrck (audio_lrck),
    .audio_dac  (audio_dac)
  );

endmodule

// ==== verification/core_bridge_tb.sv ====
//////////////////////////////////////////////////////////////////////
// core bridge testbench
// directed tests for settings, reset pulse, loader, credits and audio
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module core_bridge_tb;

  import core_bridge_pkg::*;

  localparam int reset_cycles  = 32;
  localparam int mem_credits   = 4;
  localparam int fifo_depth    = 4;
  localparam int bit_cycles    = 4;
  localparam int loader_writes = 6;
  localparam int drain_limit   = 64;
  localparam int frame_cycles  = 32 * bit_cycles;

  // rough cycle cost of each test, doubled for the watchdog
  localparam int budget_cycles = 40 + (reset_cycles + 10) + loader_writes * drain_limit
                                 + 3 * drain_limit + 4 * drain_limit + 6 * frame_cycles;
  localparam int timeout_cycles = 2 * budget_cycles;

  logic                   clk_74a = 1'b0;
  logic                   rst;
  logic                   bridge_wr;
  logic                   sound;
  bridge_word_t           bridge_addr;
  bridge_word_t           bridge_wr_data;
  bridge_word_t           bridge_rd_data;
  logic                   core_reset;
  logic                   accurate_lcd_timing;
  alpha_t                 lcd_off_alpha;
  logic                   mem_wr;
  logic [word_addr_w-1:0] mem_addr;
  halfword_t              mem_data;
  logic                   mem_credit;
  logic                   audio_mclk;
  logic                   audio_lrck;
  logic                   audio_dac;

  int                     cycle_no = 0;
  logic [31:0]            gap;
  logic                   credit_model_on = 1'b1;
  logic [15:0]            stim_lfsr = 16'd63;
  logic [15:0]            credit_lfsr = 16'd63;
  int                     credit_due[$];
  logic [word_addr_w-1:0] exp_addr[$];
  logic [word_addr_w-1:0] seen_addr[$];
  halfword_t              exp_data[$];
  halfword_t              seen_data[$];

  core_bridge_top #(
    .reset_cycles (reset_cycles),
    .mem_credits  (mem_credits),
    .fifo_depth   (fifo_depth),
    .bit_cycles   (bit_cycles)
  ) core_bridge_top_i (
    .clk_74a             (clk_74a),
    .rst                 (rst),
    .bridge_wr           (bridge_wr),
    .sound               (sound),
    .bridge_addr         (bridge_addr),
    .bridge_wr_data      (bridge_wr_data),
    .bridge_rd_data      (bridge_rd_data),
    .core_reset          (core_reset),
    .accurate_lcd_timing (accurate_lcd_timing),
    .lcd_off_alpha       (lcd_off_alpha),
    .mem_wr              (mem_wr),
    .mem_addr            (mem_addr),
    .mem_data            (mem_data),
    .mem_credit          (mem_credit),
    .audio_mclk          (audio_mclk),
    .audio_lrck          (audio_lrck),
    .audio_dac           (audio_dac)
  );

  always #10 clk_74a = ~clk_74a;

  ////////////////////////////////////////////////////////////////////
  // helpers

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
      stop_with_failure("stopping at the first mismatch");
    end
  endtask

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic take_bits(inout logic [15:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      bits  = {bits[30:0], state[0]};
    end
  endtask

  task automatic bridge_write(input bridge_word_t addr, input bridge_word_t data);
    @(negedge clk_74a);
    bridge_wr      = 1'b1;
    bridge_addr    = addr;
    bridge_wr_data = data;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic bridge_read(input bridge_word_t addr, output bridge_word_t data);
    @(negedge clk_74a);
    bridge_addr = addr;
    #1;
    data = bridge_rd_data;
  endtask

  // credit pulses never share a cycle
  task automatic schedule_credit(input int at);
    int slot;
    slot = at;
    if (credit_due.size() != 0) begin
      if (slot <= credit_due[$]) begin
        slot = credit_due[$] + 1;
      end
    end
    credit_due.push_back(slot);
  endtask

  task automatic return_credits(input int n);
    for (int i = 0; i < n; i++) begin
      schedule_credit(cycle_no + 2 + i);
    end
  endtask

  // memory side: collects writes and hands credits back
  always @(negedge clk_74a) begin
    cycle_no++;
    mem_credit = 1'b0;
    if (credit_due.size() != 0 && credit_due[0] <= cycle_no) begin
      mem_credit = 1'b1;
      credit_due.delete(0);
    end
    if (mem_wr) begin
      seen_addr.push_back(mem_addr);
      seen_data.push_back(mem_data);
      if (credit_model_on) begin
        take_bits(credit_lfsr, 3, gap);
        schedule_credit(cycle_no + 1 + gap);
      end
    end
  end

  task automatic wait_words(input int n);
    int waited;
    waited = 0;
    while (seen_addr.size() < n) begin
      if (waited > 2 * drain_limit) begin
        stop_with_failure("memory writes did not arrive in time");
      end else begin
        @(negedge clk_74a);
        waited++;
      end
    end
  endtask

  task automatic wait_credits_home();
    int waited;
    waited = 0;
    while (credit_due.size() != 0) begin
      if (waited > drain_limit) begin
        stop_with_failure("credits were not returned in time");
      end else begin
        @(negedge clk_74a);
        waited++;
      end
    end
    repeat (2) @(negedge clk_74a);
  endtask

  task automatic wait_lrck(input logic level);
    int waited;
    waited = 0;
    while (audio_lrck !== level) begin
      if (waited > frame_cycles) begin
        stop_with_failure("audio lrck stopped toggling");
      end else begin
        @(negedge clk_74a);
        waited++;
      end
    end
  endtask

  task automatic clear_words();
    exp_addr.delete();
    exp_data.delete();
    seen_addr.delete();
    seen_data.delete();
  endtask

  // region write with random offset and data
  task automatic load_word(input bit kept);
    logic [31:0]            off_bits;
    logic [31:0]            data;
    logic [word_addr_w-1:0] word_addr;
    take_bits(stim_lfsr, 24, off_bits);
    take_bits(stim_lfsr, 32, data);
    // 4-byte aligned offsets, low half stays in range
    word_addr = {off_bits[23:0], 1'b0};
    bridge_write({loader_region, 2'b00, off_bits[23:0], 2'b00}, data);
    if (kept) begin
      exp_addr.push_back(word_addr);
      exp_data.push_back(data[31:16]);
      exp_addr.push_back(word_addr + 1'b1);
      exp_data.push_back(data[15:0]);
    end
  endtask

  task automatic compare_words(input string name);
    check_value({name, " count"}, exp_addr.size(), seen_addr.size());
    for (int i = 0; i < exp_addr.size(); i++) begin
      check_value($sformatf("%s addr %0d", name, i), exp_addr[i], seen_addr[i]);
      check_value($sformatf("%s data %0d", name, i), exp_data[i], seen_data[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // tests

  task automatic check_reset_state();
    bridge_word_t rd;
    check_value("reset state mem_wr", 1'b0, mem_wr);
    check_value("reset state core_reset", 1'b0, core_reset);
    check_value("reset state timing", 1'b0, accurate_lcd_timing);
    check_value("reset state alpha", 8'd0, lcd_off_alpha);
    check_value("reset state lrck", 1'b0, audio_lrck);
    bridge_read(reg_status_addr, rd);
    check_value("reset state overflow", 32'd0, rd);
    bridge_read(reg_lcd_timing_addr, rd);
    check_value("reset state timing reg", 32'd0, rd);
    bridge_read(reg_show_off_addr, rd);
    check_value("reset state show_off reg", 32'd0, rd);
    bridge_read(reg_off_alpha_addr, rd);
    check_value("reset state alpha reg", 32'd0, rd);
  endtask

  task automatic settings_readback();
    logic [31:0]  timing_val;
    logic [31:0]  show_val;
    logic [31:0]  alpha_val;
    bridge_word_t rd;
    take_bits(stim_lfsr, 32, timing_val);
    take_bits(stim_lfsr, 32, show_val);
    take_bits(stim_lfsr, 32, alpha_val);
    bridge_write(reg_lcd_timing_addr, timing_val);
    bridge_write(reg_show_off_addr, show_val);
    bridge_write(reg_off_alpha_addr, alpha_val);
    bridge_read(reg_lcd_timing_addr, rd);
    check_value("settings timing", {31'd0, timing_val[0]}, rd);
    bridge_read(reg_show_off_addr, rd);
    check_value("settings show_off", {31'd0, show_val[0]}, rd);
    bridge_read(reg_off_alpha_addr, rd);
    check_value("settings alpha", {24'd0, alpha_val[7:0]}, rd);
    check_value("settings timing pin", timing_val[0], accurate_lcd_timing);
    check_value("settings alpha pin", show_val[0] ? alpha_val[7:0] : 8'd0, lcd_off_alpha);
    // overlay shown, then hidden
    bridge_write(reg_show_off_addr, 32'd1);
    check_value("settings alpha shown", alpha_val[7:0], lcd_off_alpha);
    bridge_write(reg_show_off_addr, 32'd0);
    check_value("settings alpha hidden", 8'd0, lcd_off_alpha);
    bridge_read(32'h0000_0300, rd);
    check_value("settings unmapped", 32'd0, rd);
  endtask

  task automatic reset_pulse_length();
    int          high;
    logic [31:0] data;
    take_bits(stim_lfsr, 32, data);
    check_value("reset idle", 1'b0, core_reset);
    bridge_write(reg_reset_addr, data);
    high = 0;
    while (core_reset && high <= reset_cycles) begin
      high++;
      @(negedge clk_74a);
    end
    check_value("reset pulse length", reset_cycles, high);
  endtask

  task automatic loader_ordering();
    bridge_word_t rd;
    credit_model_on = 1'b1;
    clear_words();
    for (int i = 0; i < loader_writes; i++) begin
      load_word(1'b1);
      wait_words(2 * (i + 1));
    end
    compare_words("loader order");
    bridge_read(reg_status_addr, rd);
    check_value("loader no overflow", 32'd0, rd);
  endtask

  task automatic credit_limit();
    int writes;
    int leftover;
    writes   = mem_credits / 2 + 1;
    leftover = 2 * writes - mem_credits;
    wait_credits_home();
    credit_model_on = 1'b0;
    clear_words();
    for (int i = 0; i < writes; i++) begin
      load_word(1'b1);
    end
    repeat (drain_limit) @(negedge clk_74a);
    check_value("credit limit count", mem_credits, seen_addr.size());
    return_credits(mem_credits);
    wait_words(2 * writes);
    compare_words("credit release");
    return_credits(leftover);
  endtask

  task automatic fifo_overflow();
    bridge_word_t rd;
    wait_credits_home();
    credit_model_on = 1'b0;
    clear_words();
    // use up the credits so the next words stay queued
    for (int i = 0; i < mem_credits / 2; i++) begin
      load_word(1'b1);
    end
    wait_words(mem_credits);
    for (int i = 0; i < fifo_depth / 2; i++) begin
      load_word(1'b1);
    end
    repeat (3) @(negedge clk_74a);
    check_value("overflow held", mem_credits, seen_addr.size());
    bridge_read(reg_status_addr, rd);
    check_value("overflow before full", 32'd0, rd);
    load_word(1'b0);
    load_word(1'b0);
    bridge_read(reg_status_addr, rd);
    check_value("overflow status", 32'd1, rd);
    return_credits(fifo_depth);
    wait_words(mem_credits + fifo_depth);
    repeat (drain_limit / 4) @(negedge clk_74a);
    compare_words("overflow");
    return_credits(mem_credits);
  endtask

  task automatic run_frame(input logic level);
    int   bit_no;
    logic exp_dac;
    @(negedge clk_74a);
    sound = level;
    wait_lrck(1'b1);
    wait_lrck(1'b0);
    for (int slot = 0; slot < 32; slot++) begin
      bit_no  = slot % 16;
      // two zero bits, thirteen sound bits, one zero pad
      exp_dac = (bit_no >= 2 && bit_no <= 14) ? level : 1'b0;
      for (int c = 0; c < bit_cycles; c++) begin
        check_value($sformatf("audio slot %0d dac", slot), exp_dac, audio_dac);
        check_value($sformatf("audio slot %0d lrck", slot), slot >= 16, audio_lrck);
        check_value($sformatf("audio slot %0d mclk", slot), c < bit_cycles / 2, audio_mclk);
        @(negedge clk_74a);
      end
    end
  endtask

  task automatic audio_framing();
    run_frame(1'b1);
    run_frame(1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin
    rst            = 1'b1;
    bridge_wr      = 1'b0;
    sound          = 1'b0;
    bridge_addr    = '0;
    bridge_wr_data = '0;
    mem_credit     = 1'b0;
    repeat (2) @(negedge clk_74a);
    rst = 1'b0;
    check_reset_state();
    settings_readback();
    reset_pulse_length();
    loader_ordering();
    credit_limit();
    fifo_overflow();
    audio_framing();
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk_74a);
    stop_with_failure("watchdog timeout, the tests did not finish");
  end

endmodule

// ==== compile.f ====
source/core_bridge_pkg.sv
source/word_if.sv
source/settings_regs.sv
source/data_loader.sv
source/mem_write_port.sv
source/sound_i2s.sv
source/core_bridge_top.sv
verification/core_bridge_tb.sv
